/* dot_engine_top.f */
logic/dot_pkg.sv
logic/row_result_if.sv
logic/mac_element.sv
logic/mac_row.sv
logic/operand_regs.sv
logic/row_combiner.sv
logic/dot_engine_top.sv
tb/tb_clk_gen.sv
tb/tb_dot_engine.sv

/* logic/dot_engine_top.sv */
`timescale 1ns/1ns

module dot_engine_top import dot_pkg::*; #(
  parameter int unsigned Height = DefaultHeight
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  logic [ADDR_W-1:0] wb_adr_i,
  input  logic [31:0]       wb_dat_i,
  input  logic [3:0]        wb_sel_i,
  output logic [31:0]       wb_dat_o,
  output logic              wb_ack_o
);

  elem_t [Height-1:0] x;
  elem_t [Height-1:0] w0;
  elem_t [Height-1:0] w1;
  elem_t              bias0;
  elem_t              bias1;
  logic               negate;
  logic               start;
  logic               flush;
  logic               result_read;
  wb_word_u           result;
  logic               done;
  logic               busy;

  row_result_if rr0 ();
  row_result_if rr1 ();

  operand_regs #(
    .Height (Height)
  ) u_regs (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_sel_i      (wb_sel_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o),
    .result_i      (result),
    .done_i        (done),
    .busy_i        (busy),
    .x_o           (x),
    .w0_o          (w0),
    .w1_o          (w1),
    .bias0_o       (bias0),
    .bias1_o       (bias1),
    .negate_o      (negate),
    .start_o       (start),
    .flush_o       (flush),
    .result_read_o (result_read)
  );

  // same x and start, separate weights and bias
  mac_row #(.Height (Height)) row0 (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (start),
    .flush_i  (flush),
    .negate_i (negate),
    .x_i      (x),
    .w_i      (w0),
    .bias_i   (bias0),
    .rr       (rr0)
  );

  mac_row #(.Height (Height)) row1 (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (start),
    .flush_i  (flush),
    .negate_i (negate),
    .x_i      (x),
    .w_i      (w1),
    .bias_i   (bias1),
    .rr       (rr1)
  );

  row_combiner u_comb (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush),
    .result_read_i (result_read),
    .row0          (rr0),
    .row1          (rr1),
    .result_o      (result),
    .done_o        (done),
    .busy_o        (busy)
  );

endmodule

/* logic/dot_pkg.sv */
package dot_pkg;

  localparam int unsigned ADDR_W        = 4;
  localparam int unsigned DefaultHeight = 4;  // elements per row, keep even

  // signed Q8.8
  typedef logic signed [15:0] elem_t;

  typedef struct packed {
    logic [26:0] rsvd;
    logic        done;    // read only
    logic        busy;    // read only
    logic        flush;   // write, one-shot
    logic        negate;  // write, reads back
    logic        start;   // write, one-shot
  } ctrl_t;

  // one bus word, either two elements (low first) or the control/status view
  typedef union packed {
    elem_t [1:0] elems;
    ctrl_t       ctrl;
  } wb_word_u;

  // word offsets, two elements per word
  localparam int unsigned OffX = 0;

  function automatic int unsigned off_w0(int unsigned h);
    return h / 2;
  endfunction

  function automatic int unsigned off_w1(int unsigned h);
    return h;
  endfunction

  function automatic int unsigned off_bias(int unsigned h);
    return (3 * h) / 2;
  endfunction

  function automatic int unsigned off_ctrl(int unsigned h);
    return (3 * h) / 2 + 1;
  endfunction

  function automatic int unsigned off_result(int unsigned h);
    return (3 * h) / 2 + 2;
  endfunction

endpackage

/* logic/mac_element.sv */
`timescale 1ns/1ns

module mac_element import dot_pkg::*; #(
  parameter  int unsigned NumOps = 1,  // operand pairs still to be used, this one included
  localparam int unsigned OutOps = (NumOps > 1) ? NumOps - 1 : 1
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    advance_i,
  input  logic                    flush_i,
  input  logic                    valid_i,
  input  logic                    negate_i,
  input  elem_t                   sum_i,
  input  elem_t [NumOps-1:0][1:0] ops_i,  // [n][0] x, [n][1] w
  output logic                    valid_o,
  output logic                    negate_o,
  output elem_t                   sum_o,
  output elem_t [OutOps-1:0][1:0] ops_o
);

  logic signed [31:0] prod;
  elem_t              prod_q;
  elem_t              sum_d;

  assign prod   = ops_i[0][0] * ops_i[0][1];
  assign prod_q = prod[23:8];  // >>> 8, then keep 16 bits
  assign sum_d  = negate_i ? sum_i - prod_q : sum_i + prod_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_o  <= 1'b0;
      negate_o <= 1'b0;
      sum_o    <= '0;
    end else if (flush_i) begin
      valid_o  <= 1'b0;
      negate_o <= 1'b0;
      sum_o    <= '0;
    end else if (advance_i) begin
      valid_o  <= valid_i;
      negate_o <= negate_i;
      sum_o    <= sum_d;
    end
  end

  // remaining pairs ride along with the item
  if (NumOps > 1) begin : gen_carry
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        ops_o <= '0;
      end else if (flush_i) begin
        ops_o <= '0;
      end else if (advance_i) begin
        ops_o <= ops_i[NumOps-1:1];
      end
    end
  end else begin : gen_last
    assign ops_o = '0;  // nothing left after the last stage
  end

endmodule

/* logic/mac_row.sv */
`timescale 1ns/1ns

module mac_row import dot_pkg::*; #(
  parameter int unsigned Height = DefaultHeight
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              start_i,
  input  logic              flush_i,
  input  logic              negate_i,
  input  elem_t [Height-1:0] x_i,
  input  elem_t [Height-1:0] w_i,
  input  elem_t             bias_i,
  row_result_if.row         rr
);

  // first operand pair of stage k in the triangular operand array
  function automatic int pair_base(int k);
    return k * Height - (k * (k - 1)) / 2;
  endfunction

  localparam int unsigned NumPairs = pair_base(Height) + 1;

  // index 0 is the row input, index k+1 the register of element k
  logic  [Height:0]          valid;
  logic  [Height:0]          neg;
  elem_t [Height:0]          sum;
  elem_t [NumPairs-1:0][1:0] ops;

  assign valid[0] = start_i;
  assign neg[0]   = negate_i;
  assign sum[0]   = bias_i;

  for (genvar j = 0; j < Height; j++) begin : gen_load
    assign ops[j][0] = x_i[j];
    assign ops[j][1] = w_i[j];
  end

  for (genvar k = 0; k < Height; k++) begin : gen_elem
    localparam int unsigned Base   = pair_base(k);
    localparam int unsigned NOps   = Height - k;
    localparam int unsigned Next   = Base + NOps;
    localparam int unsigned OutOps = (NOps > 1) ? NOps - 1 : 1;

    mac_element #(
      .NumOps (NOps)
    ) u_elem (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .advance_i (rr.advance),
      .flush_i   (flush_i),
      .valid_i   (valid[k]),
      .negate_i  (neg[k]),
      .sum_i     (sum[k]),
      .ops_i     (ops[Next-1:Base]),
      .valid_o   (valid[k+1]),
      .negate_o  (neg[k+1]),
      .sum_o     (sum[k+1]),
      .ops_o     (ops[Next+OutOps-1:Next])
    );
  end

  assign rr.valid = valid[Height];
  assign rr.z     = sum[Height];
  assign rr.busy  = |valid[Height:1];

  // the combiner relies on a stalled output holding still
  a_hold_on_stall : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !rr.advance && !flush_i |=> $stable(rr.valid) && $stable(rr.z));

endmodule

/* logic/operand_regs.sv */
`timescale 1ns/1ns

module operand_regs import dot_pkg::*; #(
  parameter int unsigned Height = DefaultHeight
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               wb_cyc_i,
  input  logic               wb_stb_i,
  input  logic               wb_we_i,
  input  logic [ADDR_W-1:0]  wb_adr_i,
  input  logic [31:0]        wb_dat_i,
  input  logic [3:0]         wb_sel_i,
  output logic [31:0]        wb_dat_o,
  output logic               wb_ack_o,
  input  wb_word_u           result_i,
  input  logic               done_i,
  input  logic               busy_i,
  output elem_t [Height-1:0] x_o,
  output elem_t [Height-1:0] w0_o,
  output elem_t [Height-1:0] w1_o,
  output elem_t              bias0_o,
  output elem_t              bias1_o,
  output logic               negate_o,
  output logic               start_o,
  output logic               flush_o,
  output logic               result_read_o
);

  localparam int unsigned OffW0     = off_w0(Height);
  localparam int unsigned OffW1     = off_w1(Height);
  localparam int unsigned OffBias   = off_bias(Height);
  localparam int unsigned OffCtrl   = off_ctrl(Height);
  localparam int unsigned OffResult = off_result(Height);

  logic        req;
  logic        wr;
  logic        rd;
  int unsigned adr;
  wb_word_u    wdat;
  wb_word_u    rdata;
  wb_word_u    dat_q;

  assign req  = wb_cyc_i & wb_stb_i & ~wb_ack_o;  // ack drops after one cycle
  assign wr   = req & wb_we_i;
  assign rd   = req & ~wb_we_i;
  assign adr  = 32'(wb_adr_i);
  assign wdat = wb_dat_i;

  assign result_read_o = rd && (adr == OffResult);  // clears done on the ack edge
  assign wb_dat_o      = dat_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_ack_o <= 1'b0;
      dat_q    <= '0;
    end else begin
      wb_ack_o <= req;
      if (rd) dat_q <= rdata;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      x_o      <= '0;
      w0_o     <= '0;
      w1_o     <= '0;
      bias0_o  <= '0;
      bias1_o  <= '0;
      negate_o <= 1'b0;
      start_o  <= 1'b0;
      flush_o  <= 1'b0;
    end else begin
      start_o <= 1'b0;
      flush_o <= 1'b0;
      if (wr) begin
        for (int i = 0; i < Height / 2; i++) begin
          if (adr == OffX + i)  x_o[2*i +: 2]  <= wdat.elems;
          if (adr == OffW0 + i) w0_o[2*i +: 2] <= wdat.elems;
          if (adr == OffW1 + i) w1_o[2*i +: 2] <= wdat.elems;
        end
        if (adr == OffBias) begin
          bias0_o <= wdat.elems[0];
          bias1_o <= wdat.elems[1];
        end
        if (adr == OffCtrl) begin
          negate_o <= wdat.ctrl.negate;
          start_o  <= wdat.ctrl.start;
          flush_o  <= wdat.ctrl.flush;
        end
      end
    end
  end

  // unmapped words read as 0
  always_comb begin
    rdata = '0;
    for (int i = 0; i < Height / 2; i++) begin
      if (adr == OffX + i)  rdata.elems = x_o[2*i +: 2];
      if (adr == OffW0 + i) rdata.elems = w0_o[2*i +: 2];
      if (adr == OffW1 + i) rdata.elems = w1_o[2*i +: 2];
    end
    if (adr == OffBias) begin
      rdata.elems[0] = bias0_o;
      rdata.elems[1] = bias1_o;
    end
    if (adr == OffCtrl) begin
      rdata.ctrl.negate = negate_o;
      rdata.ctrl.busy   = busy_i;
      rdata.ctrl.done   = done_i;
    end
    if (adr == OffResult) rdata = result_i;
  end

  a_ack_after_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_o |-> $past(wb_cyc_i && wb_stb_i));

  // word writes only, the master is expected to drive all byte lanes
  a_full_word_write : assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_cyc_i && wb_stb_i && wb_we_i |-> &wb_sel_i);

endmodule

/* logic/row_combiner.sv */
`timescale 1ns/1ns

module row_combiner import dot_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          flush_i,
  input  logic          result_read_i,
  row_result_if.sink    row0,
  row_result_if.sink    row1,
  output wb_word_u      result_o,
  output logic          done_o,
  output logic          busy_o
);

  logic both_valid;
  logic capture;
  logic advance;

  assign both_valid = row0.valid & row1.valid;
  assign capture    = both_valid & ~done_o;
  assign advance    = ~(done_o & both_valid);  // stall both rows on a held result

  assign row0.advance = advance;
  assign row1.advance = advance;

  assign busy_o = row0.busy | row1.busy | done_o;  // a held word counts as busy

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      result_o <= '0;
      done_o   <= 1'b0;
    end else if (flush_i) begin
      result_o <= '0;
      done_o   <= 1'b0;
    end else if (capture) begin
      result_o.elems[0] <= row0.z;
      result_o.elems[1] <= row1.z;
      done_o            <= 1'b1;
    end else if (result_read_i) begin
      done_o <= 1'b0;
    end
  end

  // rows start together, so items arrive in lockstep
  a_rows_matched : assert property (@(posedge clk_i) disable iff (!rst_ni)
    row0.valid == row1.valid);

  // held word is not overwritten until the host has read it
  a_no_overwrite : assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o && !result_read_i && !flush_i |=> $stable(result_o) && done_o);

endmodule

/* logic/row_result_if.sv */
`timescale 1ns/1ns

interface row_result_if import dot_pkg::*; ();

  logic  valid;
  elem_t z;
  logic  busy;     // some stage of the row holds an item
  logic  advance;  // whole row shifts one stage

  modport row (
    output valid,
    output z,
    output busy,
    input  advance
  );

  modport sink (
    input  valid,
    input  z,
    input  busy,
    output advance
  );

endinterface

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int unsigned HalfPeriod  = 10,
  parameter int unsigned ResetCycles = 16
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;  // released away from the active edge
  end

endmodule

/* tb/tb_dot_engine.sv */
`timescale 1ns/1ns

module tb_dot_engine import dot_pkg::*; ();

  localparam int unsigned Height    = DefaultHeight;
  localparam int unsigned OffCtrl   = off_ctrl(Height);
  localparam int unsigned OffResult = off_result(Height);
  localparam int          AckLimit  = 20;
  localparam int          DoneLimit = 40;  // status polls

  logic              clk;
  logic              rst_n;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [ADDR_W-1:0] wb_adr;
  logic [31:0]       wb_dat_w;
  logic [3:0]        wb_sel;
  logic [31:0]       wb_dat_r;
  logic              wb_ack;

  elem_t       op_x [Height];
  elem_t       op_w0 [Height];
  elem_t       op_w1 [Height];
  elem_t       op_b0;
  elem_t       op_b1;
  wb_word_u    exp_q[$];  // expected result words, oldest first
  logic [15:0] lfsr_state;
  int          errors;
  int          test_errors;
  int          tests_run;
  int          tests_failed;

  tb_clk_gen clk_gen0 (.clk_o (clk), .rst_no (rst_n));

  dot_engine_top #(.Height (Height)) dut0 (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_sel_i (wb_sel),
    .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack)
  );

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  // bias +/- sum of (x*w >>> 8), everything mod 2^16
  function automatic elem_t ref_dot(input elem_t xv [Height], input elem_t wv [Height],
                                    input elem_t bias, input logic neg);
    logic signed [31:0] p;
    elem_t              acc;
    acc = bias;
    for (int i = 0; i < Height; i++) begin
      p = xv[i] * wv[i];
      if (neg) acc = acc - elem_t'(p >>> 8);
      else acc = acc + elem_t'(p >>> 8);
    end
    return acc;
  endfunction

  function automatic wb_word_u pack2(elem_t lo, elem_t hi);
    wb_word_u w;
    w.elems[0] = lo;
    w.elems[1] = hi;
    return w;
  endfunction

  task automatic compare_elem(string name, elem_t got, elem_t exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_status(string name, ctrl_t got, ctrl_t exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic wb_access(input logic we, input int unsigned adr, input wb_word_u wdat,
                           output wb_word_u rdat);
    int n;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= ADDR_W'(adr);
    wb_dat_w <= wdat;
    n = 0;
    @(negedge clk);
    while (!wb_ack && n < AckLimit) begin
      @(negedge clk);
      n++;
    end
    if (!wb_ack) begin
      errors++;
      $display("Timeout at %0t: no ack for access to word %0d", $time, adr);
    end
    rdat = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_write(int unsigned adr, wb_word_u dat);
    wb_word_u unused;
    wb_access(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input int unsigned adr, output wb_word_u dat);
    wb_access(1'b0, adr, '0, dat);
  endtask

  task automatic load_operands();
    for (int i = 0; i < Height / 2; i++) begin
      wb_write(OffX + i, pack2(op_x[2*i], op_x[2*i+1]));
      wb_write(off_w0(Height) + i, pack2(op_w0[2*i], op_w0[2*i+1]));
      wb_write(off_w1(Height) + i, pack2(op_w1[2*i], op_w1[2*i+1]));
    end
    wb_write(off_bias(Height), pack2(op_b0, op_b1));
  endtask

  task automatic write_ctrl(logic start, logic neg, logic flush);
    wb_word_u w;
    w = '0;
    w.ctrl.start  = start;
    w.ctrl.negate = neg;
    w.ctrl.flush  = flush;
    wb_write(OffCtrl, w);
  endtask

  task automatic start_item(logic neg);
    exp_q.push_back(pack2(ref_dot(op_x, op_w0, op_b0, neg), ref_dot(op_x, op_w1, op_b1, neg)));
    write_ctrl(1'b1, neg, 1'b0);
  endtask

  task automatic wait_done();
    wb_word_u st;
    int       n;
    n = 0;
    wb_read(OffCtrl, st);
    while (!st.ctrl.done && n < DoneLimit) begin
      wb_read(OffCtrl, st);
      n++;
    end
    if (!st.ctrl.done) begin
      errors++;
      $display("Timeout at %0t: done never rose", $time);
    end
  endtask

  task automatic check_status(logic neg, logic busy, logic done);
    wb_word_u st;
    ctrl_t    exp;
    exp = '0;
    exp.negate = neg;
    exp.busy   = busy;
    exp.done   = done;
    wb_read(OffCtrl, st);
    compare_status("status", st.ctrl, exp);
  endtask

  task automatic read_result();
    wb_word_u got;
    wb_word_u exp;
    wb_read(OffResult, got);
    if (exp_q.size() == 0) begin
      errors++;
      $display("Result read at %0t with no result expected", $time);
    end else begin
      exp = exp_q.pop_front();
      compare_elem("result.elems[0]", got.elems[0], exp.elems[0]);
      compare_elem("result.elems[1]", got.elems[1], exp.elems[1]);
    end
  endtask

  task automatic end_test(string name);
    tests_run++;
    if (errors == test_errors) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  initial begin
    wb_word_u w;
    int       n;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = '0;
    wb_dat_w     = '0;
    wb_sel       = 4'hf;
    lfsr_state   = 16'd4;
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    n = 0;
    while (rst_n !== 1'b1 && n < 40) begin
      @(posedge clk);
      n++;
    end
    if (rst_n !== 1'b1) begin
      errors++;
      $display("Reset was never released");
    end

    check_status(1'b0, 1'b0, 1'b0);
    wb_read(OffResult, w);
    compare_elem("result.elems[0]", w.elems[0], '0);
    compare_elem("result.elems[1]", w.elems[1], '0);
    end_test("reset");

    // 1.0 2.0 -0.5 0.25, row 1 overflows past 127
    op_x  = '{16'h0100, 16'h0200, 16'hff80, 16'h0040};
    op_w0 = '{16'h0180, 16'hff00, 16'h0200, 16'h0400};
    op_w1 = '{16'h7f00, 16'h0100, 16'h0000, 16'h0000};
    op_b0 = 16'h00c0;
    op_b1 = 16'h1000;
    load_operands();
    start_item(1'b0);
    wait_done();
    read_result();
    end_test("single dot product");

    start_item(1'b1);  // same operands
    wait_done();
    read_result();
    check_status(1'b1, 1'b0, 1'b0);
    end_test("negate mode");

    start_item(1'b0);
    op_x  = '{16'hfe00, 16'h0080, 16'h0300, 16'hff00};
    op_b0 = 16'hff00;
    op_b1 = 16'h0040;
    load_operands();
    start_item(1'b0);  // second item stalls behind the held word
    wait_done();
    read_result();
    wait_done();
    read_result();
    end_test("two items in flight");

    start_item(1'b0);
    write_ctrl(1'b0, 1'b0, 1'b1);
    exp_q.delete();
    check_status(1'b0, 1'b0, 1'b0);
    start_item(1'b0);
    wait_done();
    read_result();
    end_test("flush");

    for (int t = 0; t < 20; t++) begin
      for (int i = 0; i < Height; i++) begin
        op_x[i]  = elem_t'(rand_bits(16));
        op_w0[i] = elem_t'(rand_bits(16));
        op_w1[i] = elem_t'(rand_bits(16));
      end
      op_b0 = elem_t'(rand_bits(16));
      op_b1 = elem_t'(rand_bits(16));
      load_operands();
      start_item(rand_bits(1) != 0);
      wait_done();
      read_result();
    end
    end_test("random operands");

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
